//--- Makefile
SIM := obj_dir/Vtb_analog_top

# rebuilt only when a source or the file list changes
$(SIM): vlog.f $(wildcard *.sv) tb_tasks.svh
	verilator --binary --timing -f vlog.f --top-module tb_analog_top -o Vtb_analog_top

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- adc_frontend.sv
`timescale 1ns/1ps

module adc_frontend (
  input  logic                     adc_clk,
  input  logic [rp_pkg::ADC_W-1:0] adc_dat_a_i,
  input  logic [rp_pkg::ADC_W-1:0] adc_dat_b_i,
  input  logic                     digital_loop_i,
  input  rp_pkg::sample_pair_t     dac_loop_i,
  output rp_pkg::sample_pair_t     adc_o
);

  import rp_pkg::*;

  // raw offset binary, straight off the pins
  logic [ADC_W-1:0] raw_a_q;
  logic [ADC_W-1:0] raw_b_q;

  ////////////////////////////////////////////////////////////////////////////
  // input register, ideally packed into the io blocks
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    raw_a_q <= adc_dat_a_i;
    raw_b_q <= adc_dat_b_i;
  end

  // neg slope -> two's complement, or loop back the dac register
  always_comb
  begin
    if (digital_loop_i)
      adc_o = dac_loop_i;  // already registered, no comb loop
    else
    begin
      adc_o.a = flip_ob(raw_a_q);
      adc_o.b = flip_ob(raw_b_q);
    end
  end

endmodule

//--- analog_top.sv
`timescale 1ns/1ps

module analog_top (
  input  logic                     adc_clk,
  input  logic                     rst_n_i,
  input  logic [rp_pkg::ADC_W-1:0] adc_dat_a_i,   // ch1 raw
  input  logic [rp_pkg::ADC_W-1:0] adc_dat_b_i,   // ch2 raw
  input  rp_pkg::sys_req_t         host_req_i,
  output rp_pkg::sys_rsp_t         host_rsp_o,
  output logic [rp_pkg::ADC_W-1:0] dac_dat_a_o,
  output logic [rp_pkg::ADC_W-1:0] dac_dat_b_o,
  output logic [rp_pkg::LED_W-1:0] led_o
);

  import rp_pkg::*;

  sys_req_t [N_REGIONS-1:0] region_req;  // only hk and level used
  sys_rsp_t                 hk_rsp;
  sys_rsp_t                 lvl_rsp;

  sample_pair_t adc;         // signed adc pair
  sample_pair_t dac_loop;    // registered dac pair
  sample_pair_t level;
  logic [1:0]   follow;
  logic         digital_loop;

  ////////////////////////////////////////////////////////////////////////////
  // system bus
  ////////////////////////////////////////////////////////////////////////////

  sys_bus_decoder i_dec (
    .host_req_i   (host_req_i),
    .host_rsp_o   (host_rsp_o),
    .region_req_o (region_req),
    .hk_rsp_i     (hk_rsp),
    .lvl_rsp_i    (lvl_rsp)
  );

  housekeeping_regs i_hk (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .bus_req_i      (region_req[REG_HK]),
    .bus_rsp_o      (hk_rsp),
    .adc_i          (adc),           // readback
    .digital_loop_o (digital_loop),
    .led_o          (led_o)
  );

  dac_level_regs i_lvl (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .bus_req_i (region_req[REG_LEVEL]),
    .bus_rsp_o (lvl_rsp),
    .level_o   (level),
    .follow_o  (follow)
  );

  ////////////////////////////////////////////////////////////////////////////
  // datapath, adc in -> dac out in 2 cycles
  ////////////////////////////////////////////////////////////////////////////

  adc_frontend i_adc (
    .adc_clk        (adc_clk),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .digital_loop_i (digital_loop),
    .dac_loop_i     (dac_loop),
    .adc_o          (adc)
  );

  dac_backend i_dac (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .adc_i       (adc),
    .level_i     (level),
    .follow_i    (follow),
    .dac_loop_o  (dac_loop),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o)
  );

endmodule

//--- dac_backend.sv
`timescale 1ns/1ps

module dac_backend (
  input  logic                     adc_clk,
  input  logic                     rst_n_i,
  input  rp_pkg::sample_pair_t     adc_i,
  input  rp_pkg::sample_pair_t     level_i,
  input  logic [1:0]               follow_i,
  output rp_pkg::sample_pair_t     dac_loop_o,
  output logic [rp_pkg::ADC_W-1:0] dac_dat_a_o,
  output logic [rp_pkg::ADC_W-1:0] dac_dat_b_o
);

  import rp_pkg::*;

  sample_pair_t dac_q;  // signed, also feeds the loopback

  // level + optional adc sample, clipped to 14 bit range
  function automatic logic [ADC_W-1:0] sat_sum(
    input logic [ADC_W-1:0] lvl,
    input logic [ADC_W-1:0] smp,
    input logic             en
  );
    logic [SUM_W-1:0] addend;
    logic [SUM_W-1:0] sum;
    logic [ADC_W-1:0] res;
    addend = en ? {smp[ADC_W-1], smp} : '0;  // follow off adds zero
    sum    = {lvl[ADC_W-1], lvl} + addend;
    if (sum[SUM_W-1] ^ sum[SUM_W-2])         // overflow, top bits disagree
      res = {sum[SUM_W-1], {(ADC_W-1){~sum[SUM_W-1]}}};
    else
      res = sum[ADC_W-1:0];
    return res;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      dac_q <= '0;  // mid scale, 0x1fff at the pins
    else
    begin
      dac_q.a <= sat_sum(level_i.a, adc_i.a, follow_i[0]);
      dac_q.b <= sat_sum(level_i.b, adc_i.b, follow_i[1]);
    end
  end

  assign dac_loop_o = dac_q;

  // back to neg slope offset binary for the converter
  assign dac_dat_a_o = flip_ob(dac_q.a);
  assign dac_dat_b_o = flip_ob(dac_q.b);

endmodule

//--- dac_level_regs.sv
`timescale 1ns/1ps

module dac_level_regs (
  input  logic                 adc_clk,
  input  logic                 rst_n_i,
  input  rp_pkg::sys_req_t     bus_req_i,
  output rp_pkg::sys_rsp_t     bus_rsp_o,
  output rp_pkg::sample_pair_t level_o,
  output logic [1:0]           follow_o
);

  import rp_pkg::*;

  sample_pair_t     level_q;   // signed dc levels
  logic [1:0]       follow_q;  // bit0 ch a, bit1 ch b
  logic             ack_q;
  logic [BUS_W-1:0] rdata_q;
  logic [BUS_W-1:0] rd_mux;

  // control regs, write at strobe edge
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      level_q  <= '0;
      follow_q <= 2'b00;
      ack_q    <= 1'b0;
    end
    else
    begin
      ack_q <= bus_req_i.wen | bus_req_i.ren;
      if (bus_req_i.wen)
      begin
        case (bus_req_i.addr.f.offset)
          OFS_LVL_A:  level_q.a <= bus_req_i.wdata[ADC_W-1:0];  // low bits only
          OFS_LVL_B:  level_q.b <= bus_req_i.wdata[ADC_W-1:0];
          OFS_FOLLOW: follow_q  <= bus_req_i.wdata[1:0];
          default:    ;
        endcase
      end
    end
  end

  // readback, levels sign extended
  always_comb
  begin
    case (bus_req_i.addr.f.offset)
      OFS_LVL_A:  rd_mux = {{(BUS_W-ADC_W){level_q.a[ADC_W-1]}}, level_q.a};
      OFS_LVL_B:  rd_mux = {{(BUS_W-ADC_W){level_q.b[ADC_W-1]}}, level_q.b};
      OFS_FOLLOW: rd_mux = {{(BUS_W-2){1'b0}}, follow_q};
      default:    rd_mux = '0;
    endcase
  end

  always_ff @(posedge adc_clk)
  begin
    if (bus_req_i.ren)
      rdata_q <= rd_mux;
  end

  assign bus_rsp_o = '{rdata: rdata_q, err: 1'b0, ack: ack_q};
  assign level_o   = level_q;
  assign follow_o  = follow_q;

endmodule

//--- housekeeping_regs.sv
`timescale 1ns/1ps

module housekeeping_regs (
  input  logic                     adc_clk,
  input  logic                     rst_n_i,
  input  rp_pkg::sys_req_t         bus_req_i,
  output rp_pkg::sys_rsp_t         bus_rsp_o,
  input  rp_pkg::sample_pair_t     adc_i,
  output logic                     digital_loop_o,
  output logic [rp_pkg::LED_W-1:0] led_o
);

  import rp_pkg::*;

  logic             loop_q;   // adc <- dac when set
  logic [LED_W-1:0] led_q;
  logic             ack_q;
  logic [BUS_W-1:0] rdata_q;
  logic [BUS_W-1:0] rd_mux;

  ////////////////////////////////////////////////////////////////////////////
  // write side
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      loop_q <= 1'b0;
      led_q  <= '0;
    end
    else if (bus_req_i.wen)
    begin
      case (bus_req_i.addr.f.offset)
        OFS_LOOP: loop_q <= bus_req_i.wdata[0];
        OFS_LED:  led_q  <= bus_req_i.wdata[LED_W-1:0];
        default:  ;                                     // id and adc are read only
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read side
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (bus_req_i.addr.f.offset)
      OFS_ID:    rd_mux = HK_ID;
      OFS_LOOP:  rd_mux = {{(BUS_W-1){1'b0}}, loop_q};
      OFS_LED:   rd_mux = {{(BUS_W-LED_W){1'b0}}, led_q};
      OFS_ADC_A: rd_mux = {{(BUS_W-ADC_W){adc_i.a[ADC_W-1]}}, adc_i.a};  // sign ext
      OFS_ADC_B: rd_mux = {{(BUS_W-ADC_W){adc_i.b[ADC_W-1]}}, adc_i.b};
      default:   rd_mux = '0;                                            // holes read 0
    endcase
  end

  // ack one cycle after either strobe
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      ack_q <= 1'b0;
    else
      ack_q <= bus_req_i.wen | bus_req_i.ren;
  end

  always_ff @(posedge adc_clk)
  begin
    if (bus_req_i.ren)
      rdata_q <= rd_mux;  // adc value captured at the strobe edge
  end

  assign bus_rsp_o      = '{rdata: rdata_q, err: 1'b0, ack: ack_q};
  assign digital_loop_o = loop_q;
  assign led_o          = led_q;

endmodule

//--- rp_pkg.sv
package rp_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths and region map
  ////////////////////////////////////////////////////////////////////////////

  localparam int ADC_W     = 14;                         // adc/dac sample width
  localparam int SUM_W     = 15;                         // dac sum, one guard bit
  localparam int BUS_W     = 32;                         // bus data and address
  localparam int LED_W     = 8;
  localparam int N_REGIONS = 8;
  localparam int REGION_W  = 3;                          // addr bits 22:20
  localparam int OFS_W     = 20;                         // addr bits 19:0
  localparam int SPARE_W   = BUS_W - REGION_W - OFS_W;   // upper bits, ignored

  localparam logic [REGION_W-1:0] REG_HK    = 3'd0;  // housekeeping
  localparam logic [REGION_W-1:0] REG_LEVEL = 3'd1;  // dc level / follow

  localparam logic [BUS_W-1:0] HK_ID = 32'h5250_0A11;

  // region 0 offsets
  localparam logic [OFS_W-1:0] OFS_ID    = 20'h0;
  localparam logic [OFS_W-1:0] OFS_LOOP  = 20'h4;
  localparam logic [OFS_W-1:0] OFS_LED   = 20'h8;
  localparam logic [OFS_W-1:0] OFS_ADC_A = 20'hC;
  localparam logic [OFS_W-1:0] OFS_ADC_B = 20'h10;
  // region 1 offsets
  localparam logic [OFS_W-1:0] OFS_LVL_A  = 20'h0;
  localparam logic [OFS_W-1:0] OFS_LVL_B  = 20'h4;
  localparam logic [OFS_W-1:0] OFS_FOLLOW = 20'h8;

  ////////////////////////////////////////////////////////////////////////////
  // bus types
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [SPARE_W-1:0]  spare;   // 31:23
    logic [REGION_W-1:0] region;  // 22:20, picks the block
    logic [OFS_W-1:0]    offset;  // 19:0, register within block
  } sys_addr_f_t;

  // same address word, raw or split
  typedef union packed {
    logic [BUS_W-1:0] raw;
    sys_addr_f_t      f;
  } sys_addr_u;

  typedef struct packed {
    sys_addr_u        addr;   // held until ack
    logic [BUS_W-1:0] wdata;
    logic             wen;    // one cycle pulse
    logic             ren;    // one cycle pulse
  } sys_req_t;

  typedef struct packed {
    logic [BUS_W-1:0] rdata;  // valid with ack
    logic             err;
    logic             ack;
  } sys_rsp_t;

  typedef struct packed {
    logic signed [ADC_W-1:0] a;  // channel 1
    logic signed [ADC_W-1:0] b;  // channel 2
  } sample_pair_t;

  // negative-slope offset binary <-> two's complement, same in both directions
  function automatic logic [ADC_W-1:0] flip_ob(input logic [ADC_W-1:0] v);
    return {v[ADC_W-1], ~v[ADC_W-2:0]};
  endfunction

endpackage

//--- sys_bus_decoder.sv
`timescale 1ns/1ps

module sys_bus_decoder (
  input  rp_pkg::sys_req_t                         host_req_i,
  output rp_pkg::sys_rsp_t                         host_rsp_o,
  output rp_pkg::sys_req_t [rp_pkg::N_REGIONS-1:0] region_req_o,
  input  rp_pkg::sys_rsp_t                         hk_rsp_i,
  input  rp_pkg::sys_rsp_t                         lvl_rsp_i
);

  import rp_pkg::*;

  logic [N_REGIONS-1:0]     cs;     // one-hot region select
  sys_rsp_t [N_REGIONS-1:0] rsp;    // per region responses
  logic [N_REGIONS-1:0]     err_v;
  logic [N_REGIONS-1:0]     ack_v;

  ////////////////////////////////////////////////////////////////////////////
  // request side
  ////////////////////////////////////////////////////////////////////////////

  assign cs = N_REGIONS'(1) << host_req_i.addr.f.region;

  // every region sees addr/wdata, only the selected one gets a strobe
  always_comb
  begin
    for (int i = 0; i < N_REGIONS; i++)
    begin
      region_req_o[i]     = host_req_i;
      region_req_o[i].wen = host_req_i.wen & cs[i];
      region_req_o[i].ren = host_req_i.ren & cs[i];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // response side
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int i = 0; i < N_REGIONS; i++)
      rsp[i] = '{rdata: '0, err: 1'b0, ack: 1'b1};  // empty regions, ack held high
    rsp[REG_HK]    = hk_rsp_i;
    rsp[REG_LEVEL] = lvl_rsp_i;
  end

  always_comb
  begin
    for (int i = 0; i < N_REGIONS; i++)
    begin
      err_v[i] = rsp[i].err;
      ack_v[i] = rsp[i].ack;
    end
  end

  // rdata by index, err/ack gated by select
  assign host_rsp_o = '{
    rdata: rsp[host_req_i.addr.f.region].rdata,
    err:   |(cs & err_v),
    ack:   |(cs & ack_v)
  };

endmodule

//--- tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

////////////////////////////////////////////////////////////////////////////
// reference model
////////////////////////////////////////////////////////////////////////////

// neg slope offset binary word -> signed value
function automatic int adc_value(input logic [13:0] raw);
  int r;
  r = int'(raw[12:0]);
  return raw[13] ? (-1 - r) : (8191 - r);  // 0x0000 is full scale positive
endfunction

// 14 bit two's complement word -> int
function automatic int signed14(input logic [13:0] w);
  return w[13] ? (int'(w) - 16384) : int'(w);
endfunction

// level plus optional sample, clamped to the 14 bit range
function automatic int clip_sum(input int lvl, input int smp, input bit en);
  int s;
  s = lvl + (en ? smp : 0);
  if (s > 8191)
    s = 8191;
  else if (s < -8192)
    s = -8192;
  return s;
endfunction

// signed value -> neg slope offset binary for the dac pins
function automatic logic [13:0] dac_word(input int v);
  if (v >= 0)
    return {1'b0, 13'(8191 - v)};
  else
    return {1'b1, 13'(-1 - v)};
endfunction

////////////////////////////////////////////////////////////////////////////
// checks and bus access
////////////////////////////////////////////////////////////////////////////

task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
  assert (got === exp)
  else
  begin
    $display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
    abort_run();
  end
endtask

// one strobe, then wait for ack; the strobe drops on the ack cycle
task automatic bus_access(input logic [2:0] region, input logic [19:0] ofs, input bit wr,
                          input logic [31:0] wdata, output logic [31:0] rdata);
  int lat;
  @(negedge adc_clk);
  host_req.addr.raw      = '0;
  host_req.addr.f.region = region;
  host_req.addr.f.offset = ofs;
  host_req.wdata         = wdata;
  host_req.wen           = wr;
  host_req.ren           = !wr;
  @(negedge adc_clk);
  lat = 1;
  while (!host_rsp.ack)
  begin
    if (lat >= 4)
    begin
      $display("no ack from region %0d offset 0x%05h", region, ofs);
      abort_run();
    end
    else
    begin
      @(negedge adc_clk);
      lat++;
    end
  end
  assert (lat == 1)
  else
  begin
    $display("ack came %0d cycles after the strobe instead of 1", lat);
    abort_run();
  end
  expect_eq("host_rsp_o.err", 32'(host_rsp.err), 32'h0);
  rdata        = host_rsp.rdata;  // valid with ack
  host_req.wen = 1'b0;
  host_req.ren = 1'b0;
endtask

task automatic bus_write(input logic [2:0] region, input logic [19:0] ofs,
                         input logic [31:0] data);
  logic [31:0] unused;
  bus_access(region, ofs, 1'b1, data, unused);
endtask

task automatic bus_read(input logic [2:0] region, input logic [19:0] ofs,
                        output logic [31:0] data);
  bus_access(region, ofs, 1'b0, 32'h0, data);
endtask

`endif

//--- tb_analog_top.sv
`timescale 1ns/1ps

module tb_analog_top;

  import rp_pkg::*;

  localparam int MAX_CYCLES = 2000;  // whole sequence is ~180 cycles

  logic        adc_clk;
  logic        rst_n;
  logic [13:0] adc_a;
  logic [13:0] adc_b;
  sys_req_t    host_req;
  sys_rsp_t    host_rsp;
  logic [13:0] dac_a;
  logic [13:0] dac_b;
  logic [7:0]  led;

  int          cycles = 0;
  int          lvl_a  = 0;     // levels as the dut should hold them
  int          lvl_b  = 0;
  logic [1:0]  fol    = 2'b00;

  analog_top DUT (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n),
    .adc_dat_a_i (adc_a),
    .adc_dat_b_i (adc_b),
    .host_req_i  (host_req),
    .host_rsp_o  (host_rsp),
    .dac_dat_a_o (dac_a),
    .dac_dat_b_o (dac_b),
    .led_o       (led)
  );

  task automatic abort_run();
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  `include "tb_tasks.svh"

  initial
  begin
    adc_clk = 1'b0;
    forever #50 adc_clk = ~adc_clk;
  end

  always @(posedge adc_clk)
  begin
    cycles++;
    if (cycles >= MAX_CYCLES)
    begin
      $display("timeout, test sequence still running after %0d cycles", cycles);
      abort_run();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  // raw words within 16 codes of either rail
  function automatic logic [13:0] near_rail();
    return ($urandom % 2) ? 14'($urandom % 16) : 14'(16383 - $urandom % 16);
  endfunction

  task automatic set_levels(input logic [31:0] wa, input logic [31:0] wb);
    bus_write(REG_LEVEL, OFS_LVL_A, wa);
    bus_write(REG_LEVEL, OFS_LVL_B, wb);
    lvl_a = signed14(wa[13:0]);  // upper bits dropped
    lvl_b = signed14(wb[13:0]);
  endtask

  task automatic set_follow(input logic [1:0] f);
    bus_write(REG_LEVEL, OFS_FOLLOW, {30'h0, f});
    fol = f;
  endtask

  // new raw pair every cycle with the dac checked 2 cycles later
  task automatic run_stream(input int n, input bit rails);
    logic [13:0] exp_a[$];
    logic [13:0] exp_b[$];
    for (int i = 0; i < n + 2; i++)
    begin
      if (i >= 2)
      begin
        expect_eq("dac_dat_a_o", 32'(dac_a), 32'(exp_a.pop_front()));
        expect_eq("dac_dat_b_o", 32'(dac_b), 32'(exp_b.pop_front()));
      end
      if (i < n)
      begin
        adc_a = rails ? near_rail() : 14'($urandom);
        adc_b = rails ? near_rail() : 14'($urandom);
        exp_a.push_back(dac_word(clip_sum(lvl_a, adc_value(adc_a), fol[0])));
        exp_b.push_back(dac_word(clip_sum(lvl_b, adc_value(adc_b), fol[1])));
      end
      @(negedge adc_clk);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic reset_and_id();
    logic [31:0] rd;
    expect_eq("dac_dat_a_o", 32'(dac_a), 32'h1FFF);  // signed zero
    expect_eq("dac_dat_b_o", 32'(dac_b), 32'h1FFF);
    expect_eq("led_o", 32'(led), 32'h0);
    bus_read(REG_HK, OFS_ID, rd);
    expect_eq("host_rsp_o.rdata (id)", rd, HK_ID);
  endtask

  task automatic register_map();
    logic [31:0] rd;
    logic [7:0]  led_val;
    logic [2:0]  region;
    led_val = 8'($urandom);
    bus_write(REG_HK, OFS_LED, {24'($urandom), led_val});
    bus_read(REG_HK, OFS_LED, rd);
    expect_eq("host_rsp_o.rdata (led)", rd, 32'(led_val));
    expect_eq("led_o", 32'(led), 32'(led_val));
    bus_write(REG_HK, OFS_LOOP, 32'h1);
    bus_read(REG_HK, OFS_LOOP, rd);
    expect_eq("host_rsp_o.rdata (loop)", rd, 32'h1);
    bus_write(REG_HK, OFS_LOOP, 32'h0);
    bus_read(REG_HK, OFS_LOOP, rd);
    expect_eq("host_rsp_o.rdata (loop)", rd, 32'h0);
    set_levels($urandom, $urandom);
    bus_read(REG_LEVEL, OFS_LVL_A, rd);
    expect_eq("host_rsp_o.rdata (level a)", rd, 32'(lvl_a));  // sign extended
    bus_read(REG_LEVEL, OFS_LVL_B, rd);
    expect_eq("host_rsp_o.rdata (level b)", rd, 32'(lvl_b));
    set_follow(2'b11);
    bus_read(REG_LEVEL, OFS_FOLLOW, rd);
    expect_eq("host_rsp_o.rdata (follow)", rd, 32'h3);
    set_follow(2'b00);
    region = 3'(2 + $urandom % 6);                           // empty regions
    bus_read(region, 20'($urandom) & 20'hFFFFC, rd);
    expect_eq("host_rsp_o.rdata (unused region)", rd, 32'h0);
    bus_read(REG_HK, 20'h14, rd);                            // hole after adc b
    expect_eq("host_rsp_o.rdata (undefined offset)", rd, 32'h0);
  endtask

  task automatic adc_conversion();
    logic [31:0] rd;
    for (int i = 0; i < 8; i++)
    begin
      adc_a = 14'($urandom);
      adc_b = 14'($urandom);
      bus_read(REG_HK, OFS_ADC_A, rd);
      expect_eq("host_rsp_o.rdata (adc a)", rd, 32'(adc_value(adc_a)));
      bus_read(REG_HK, OFS_ADC_B, rd);
      expect_eq("host_rsp_o.rdata (adc b)", rd, 32'(adc_value(adc_b)));
    end
  endtask

  task automatic level_follow_path();
    set_follow(2'b00);
    set_levels($urandom, $urandom);
    @(negedge adc_clk);                                    // dac register lags a cycle
    expect_eq("dac_dat_a_o", 32'(dac_a), 32'(dac_word(lvl_a)));
    expect_eq("dac_dat_b_o", 32'(dac_b), 32'(dac_word(lvl_b)));
    set_follow(2'b11);
    run_stream(16, 1'b0);
    set_follow(2'b01);                                     // b back to level only
    run_stream(8, 1'b0);
  endtask

  task automatic saturation_limits();
    set_follow(2'b11);
    set_levels(32'h1FFF, 32'h2000);                        // both rails
    adc_a = 14'h0000;                                      // +8191
    adc_b = 14'h3FFF;                                      // -8192
    repeat (2) @(negedge adc_clk);
    expect_eq("dac_dat_a_o", 32'(dac_a), 32'h0000);
    expect_eq("dac_dat_b_o", 32'(dac_b), 32'h3FFF);
    set_levels(32'h1FFF - $urandom % 8, 32'h2000 + $urandom % 8);
    run_stream(12, 1'b1);
    set_levels(32'h2000 + $urandom % 8, 32'h1FFF - $urandom % 8);
    run_stream(12, 1'b1);
  endtask

  task automatic digital_loopback();
    logic [31:0] rd;
    set_follow(2'b00);
    set_levels($urandom, $urandom);
    bus_write(REG_HK, OFS_LOOP, 32'h1);
    for (int i = 0; i < 4; i++)
    begin
      adc_a = 14'($urandom);                               // must be ignored
      adc_b = 14'($urandom);
      bus_read(REG_HK, OFS_ADC_A, rd);
      expect_eq("host_rsp_o.rdata (adc a loop)", rd, 32'(lvl_a));
      bus_read(REG_HK, OFS_ADC_B, rd);
      expect_eq("host_rsp_o.rdata (adc b loop)", rd, 32'(lvl_b));
    end
    expect_eq("dac_dat_a_o", 32'(dac_a), 32'(dac_word(lvl_a)));
    bus_write(REG_HK, OFS_LOOP, 32'h0);
  endtask

  initial
  begin
    void'($urandom(98653));
    host_req = '0;
    adc_a    = 14'h1FFF;  // mid scale
    adc_b    = 14'h1FFF;
    rst_n    = 1'b0;
    repeat (3) @(negedge adc_clk);
    rst_n = 1'b1;
    reset_and_id();
    register_map();
    adc_conversion();
    level_follow_path();
    saturation_limits();
    digital_loopback();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+.
rp_pkg.sv
sys_bus_decoder.sv
housekeeping_regs.sv
dac_level_regs.sv
adc_frontend.sv
dac_backend.sv
analog_top.sv
tb_analog_top.sv
